// File: verilog.f
+incdir+include
hdl/up_isa_pkg.sv
hdl/up_apb_pkg.sv
hdl/up_control.sv
hdl/up_datapath.sv
hdl/up_step_counter.sv
hdl/up_apb_regs.sv
hdl/up_core_top.sv
dv/up_tb.sv

// File: Bender.yml
package:
  name: up_core

sources:
  - files:
      - hdl/up_isa_pkg.sv
      - hdl/up_apb_pkg.sv
      - hdl/up_control.sv
      - hdl/up_datapath.sv
      - hdl/up_step_counter.sv
      - hdl/up_apb_regs.sv
      - hdl/up_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/up_tb.sv

// File: include/up_tb_model.svh
`ifndef UP_TB_MODEL_SVH
`define UP_TB_MODEL_SVH

// Architectural reset state of the ISA
function automatic up_isa_pkg::core_regs_t model_reset_regs();
   up_isa_pkg::core_regs_t r;
   r.r0 = 8'h00;
   r.r1 = 8'h0A;
   r.r2 = 8'h01;
   r.r3 = 8'h81;
   r.pc = 8'h00;
   r.sp = 8'hFF;
   return r;
endfunction

function automatic logic [3:0] model_nibble(const ref logic [7:0] mem [up_apb_pkg::MEM_BYTES],
                                            input logic [7:0] pc);
   logic [7:0] b;
   b = mem[pc[7:1]];
   return pc[0] ? b[3:0] : b[7:4];  // High nibble first
endfunction

// Returns 1 when the program halts or hits the step limit within max_steps
function automatic bit model_run(ref logic [7:0] mem [up_apb_pkg::MEM_BYTES],
                                 ref up_isa_pkg::core_regs_t r,
                                 input logic [7:0] limit,
                                 input int max_steps,
                                 output logic [7:0] count,
                                 output logic expired);
   up_isa_pkg::opcode_e op;
   count = 8'h00;
   expired = 1'b0;
   for (int i = 0; i < max_steps; i++) begin
      op = up_isa_pkg::opcode_e'(model_nibble(mem, r.pc));
      r.pc = r.pc + 8'd1;
      case (op)
         up_isa_pkg::OP_HLT:  return 1'b1;
         up_isa_pkg::OP_ADD:  r.r0 = r.r1 + r.r2;
         up_isa_pkg::OP_SUB:  r.r0 = r.r1 - r.r2;
         up_isa_pkg::OP_MUL:  r.r0 = r.r1 * r.r2;
         up_isa_pkg::OP_DIV:  r.r0 = (r.r2 == 8'h00) ? 8'hFF : r.r1 / r.r2;
         up_isa_pkg::OP_MV1:  r.r1 = r.r0;
         up_isa_pkg::OP_MV2:  r.r2 = r.r0;
         up_isa_pkg::OP_MV3:  r.r3 = r.r0;
         up_isa_pkg::OP_INC:  r.r0 = r.r0 + 8'd1;
         up_isa_pkg::OP_NAND: r.r0 = ~(r.r1 & r.r2);
         up_isa_pkg::OP_LDM:  r.r0 = mem[r.r3[6:0]];
         up_isa_pkg::OP_STM:  mem[r.r3[6:0]] = r.r0;
         up_isa_pkg::OP_PUSH: begin
            r.sp = r.sp - 8'd1;
            mem[r.sp[6:0]] = r.r0;
         end
         up_isa_pkg::OP_POP: begin
            r.r0 = mem[r.sp[6:0]];
            r.sp = r.sp + 8'd1;
         end
         up_isa_pkg::OP_JZ: begin
            if (r.r1 == r.r2) r.pc = {r.r3[6:0], 1'b0};
         end
         default: begin  // LDI
            r.r0 = {model_nibble(mem, r.pc), model_nibble(mem, r.pc + 8'd1)};
            r.pc = r.pc + 8'd2;
         end
      endcase
      if (limit != 8'h00 && count + 8'd1 == limit) expired = 1'b1;
      if (count != 8'hFF) count = count + 8'd1;
      if (expired) return 1'b1;
   end
   return 1'b0;
endfunction

`endif

// File: dv/up_tb.sv
`timescale 1ns/10ps

module up_tb;
   import up_isa_pkg::*;
   import up_apb_pkg::*;

   `include "up_tb_model.svh"

   localparam int POLL_LIMIT = 2000;
   localparam int MODEL_STEPS = 1000;
   localparam int RANDOM_TESTS = 50;

   logic        clk = 1'b0;
   logic        nRst;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;

   logic [7:0]  model_mem [MEM_BYTES];
   logic [3:0]  prog [$];
   logic [31:0] rng_state = 32'hd6ca;
   int          error_count = 0;
   int          check_count = 0;
   int          test_count = 0;
   int          failed_tests = 0;
   bit          timed_out = 1'b0;

   up_core_top UUT (
      .clk     (clk),
      .nRst    (nRst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   // Odd multiplier spreads every address bit over the byte
   function automatic logic [7:0] memory_fill(input int a);
      return 8'((a * 29 + 7) ^ 8'h96);
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic compare_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      check_count++;
      if (got !== exp) report_error($sformatf("%s read %02h, expected %02h", what, got, exp));
   endtask

   task automatic compare_regs(input string what, input core_regs_t got, input core_regs_t exp);
      check_count++;
      if (got !== exp) begin
         report_error($sformatf("%s regs r0..sp read %012h, expected %012h", what, got, exp));
      end
   endtask

   task automatic compare_status(input string what, input logic [7:0] got,
                                 input logic exp_halted, input logic exp_expired);
      compare_byte(what, got, {6'b0, exp_expired, exp_halted});
   endtask

   task automatic compare_flag(input string what, input logic got, input logic exp);
      check_count++;
      if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   // Setup and access phase, then the bus goes idle
   task automatic apb_transfer(input logic write, input logic [7:0] addr, input logic [7:0] wdata,
                               output logic [7:0] rdata, output logic slverr);
      @(negedge clk);
      apb_req.psel = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite = write;
      apb_req.paddr = addr;
      apb_req.pwdata = wdata;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #2;  // Mid access phase, before the completing edge
      rdata = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      compare_flag($sformatf("pready at %02h", addr), apb_rsp.pready, 1'b1);
      @(posedge clk);
      @(negedge clk);
      apb_req.psel = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
      logic [7:0] rdata;
      logic       slverr;
      apb_transfer(1'b1, addr, data, rdata, slverr);
      compare_flag($sformatf("pslverr on write to %02h", addr), slverr, 1'b0);
   endtask

   task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
      logic slverr;
      apb_transfer(1'b0, addr, 8'h00, data, slverr);
      compare_flag($sformatf("pslverr on read of %02h", addr), slverr, 1'b0);
   endtask

   task automatic expect_slverr(input logic write, input logic [7:0] addr);
      logic [7:0] rdata;
      logic       slverr;
      apb_transfer(write, addr, 8'h77, rdata, slverr);
      compare_flag($sformatf("pslverr on %s %02h", write ? "write" : "read", addr), slverr, 1'b1);
   endtask

   task automatic read_regs(output core_regs_t r);
      logic [7:0] b [REG_COUNT];
      for (int i = 0; i < REG_COUNT; i++) begin
         host_read(REG_BASE + 8'(i), b[i]);
      end
      r = {b[0], b[1], b[2], b[3], b[4], b[5]};
   endtask

   task automatic apply_reset();
      @(negedge clk);
      nRst = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      nRst = 1'b1;
   endtask

   // Fill pattern first, program nibbles high nibble first
   task automatic load_memory();
      for (int a = 0; a < MEM_BYTES; a++) model_mem[a] = memory_fill(a);
      for (int i = 0; i < prog.size(); i++) begin
         if (i % 2 == 0) model_mem[i / 2][7:4] = prog[i];
         else model_mem[i / 2][3:0] = prog[i];
      end
      for (int a = 0; a < MEM_BYTES; a++) host_write(8'(a), model_mem[a]);
   endtask

   task automatic prepare_run(input logic [7:0] limit);
      apply_reset();
      load_memory();
      host_write(LIMIT_ADDR, limit);
   endtask

   task automatic wait_halt();
      logic [7:0] status;
      int         polls;
      polls = 0;
      status = 8'h00;
      while (!status[0] && polls < POLL_LIMIT) begin
         host_read(STATUS_ADDR, status);
         polls++;
      end
      if (!status[0]) begin
         $display("Timeout: core still running after %0d status polls", POLL_LIMIT);
         timed_out = 1'b1;
      end
   endtask

   task automatic check_results(input logic [7:0] limit);
      core_regs_t exp_regs;
      core_regs_t got_regs;
      logic [7:0] exp_count;
      logic       exp_expired;
      logic [7:0] got;
      bit         stopped;
      exp_regs = model_reset_regs();
      stopped = model_run(model_mem, exp_regs, limit, MODEL_STEPS, exp_count, exp_expired);
      if (!stopped) report_error("model ran past its step budget without stopping");
      read_regs(got_regs);
      compare_regs("after halt", got_regs, exp_regs);
      host_read(STATUS_ADDR, got);
      compare_status("STATUS after halt", got, 1'b1, exp_expired);
      host_read(COUNT_ADDR, got);
      compare_byte("COUNT", got, exp_count);
      for (int a = 0; a < MEM_BYTES; a++) begin
         host_read(8'(a), got);
         compare_byte($sformatf("mem[%02h]", a), got, model_mem[a]);
      end
   endtask

   task automatic run_program(input logic [7:0] limit);
      prepare_run(limit);
      host_write(CTRL_ADDR, 8'h01);
      wait_halt();
      if (!timed_out) check_results(limit);
   endtask

   task automatic end_test(input string name, input int errs_before);
      int errs;
      errs = error_count - errs_before;
      test_count++;
      if (errs != 0 || timed_out) failed_tests++;
      $display("Test %-12s %s, %0d errors", name, (errs == 0 && !timed_out) ? "ok" : "fail", errs);
   endtask

   task automatic test_reset_values();
      core_regs_t got;
      logic [7:0] status;
      int         errs;
      errs = error_count;
      apply_reset();
      host_read(STATUS_ADDR, status);
      compare_status("STATUS after reset", status, 1'b1, 1'b0);
      read_regs(got);
      compare_regs("after reset", got, {8'h00, 8'h0A, 8'h01, 8'h81, 8'h00, 8'hFF});
      end_test("reset", errs);
   endtask

   task automatic test_apb_errors();
      logic [7:0] got;
      int         errs;
      errs = error_count;
      prog = '{4'hE, 4'h0, 4'h5, 4'h4, 4'h5, 4'hE, 4'h0, 4'h0, 4'h6, 4'hD};  // Endless JZ loop
      prepare_run(8'd100);
      host_write(CTRL_ADDR, 8'h01);
      expect_slverr(1'b1, 8'h40);
      expect_slverr(1'b0, 8'h40);
      expect_slverr(1'b0, REG_BASE);
      wait_halt();
      if (!timed_out) begin
         check_results(8'd100);
         expect_slverr(1'b1, 8'hA0);
         expect_slverr(1'b0, 8'h8A);
         expect_slverr(1'b1, STATUS_ADDR);
         host_read(STATUS_ADDR, got);
         compare_status("STATUS after failed write", got, 1'b1, 1'b1);
         expect_slverr(1'b1, COUNT_ADDR);
         host_read(COUNT_ADDR, got);
         compare_byte("COUNT after failed write", got, 8'd100);
         host_read(LIMIT_ADDR, got);
         compare_byte("LIMIT", got, 8'd100);
      end
      end_test("apb_errors", errs);
   endtask

   task automatic test_arith();
      int errs;
      errs = error_count;
      prog = '{4'h0, 4'h4, 4'h1, 4'h5, 4'h2, 4'h8, 4'h7, 4'h3, 4'h6,
               4'hE, 4'h0, 4'h0, 4'h5, 4'h3, 4'h4, 4'h7, 4'hF};  // Ends with divide by zero
      run_program(8'd0);
      end_test("arith", errs);
   endtask

   task automatic test_memory();
      int errs;
      errs = error_count;
      prog = '{4'hC, 4'hB, 4'hE, 4'h5, 4'hA, 4'hB, 4'h7, 4'hB, 4'hE, 4'h6, 4'h0,
               4'h6, 4'h7, 4'hA, 4'hE, 4'h0, 4'h0, 4'h9, 4'hC, 4'h4, 4'hC, 4'h5,
               4'hC, 4'h0, 4'hF};  // sp wraps FF to 00 and back
      run_program(8'd0);
      end_test("memory", errs);
   endtask

   task automatic test_jump();
      int errs;
      errs = error_count;
      prog = '{4'hD, 4'h7, 4'hF};  // Not taken
      run_program(8'd0);
      if (!timed_out) begin
         prog = '{4'hE, 4'h0, 4'h5, 4'h6, 4'h4, 4'h5, 4'hD, 4'h7, 4'h7, 4'hF, 4'h7, 4'hF};
         run_program(8'd0);
      end
      if (!timed_out) begin
         // Loops back once, then falls through
         prog = '{4'hE, 4'h0, 4'h6, 4'h5, 4'hE, 4'h0, 4'h5, 4'h6, 4'h4, 4'h4,
                  4'h7, 4'h4, 4'hD, 4'hF};
         run_program(8'd0);
      end
      end_test("jump", errs);
   endtask

   task automatic test_random(input int idx);
      int         len;
      logic [7:0] limit;
      int         errs;
      errs = error_count;
      len = 8 + int'(next_random() % 40);
      limit = 8'(1 + next_random() % 64);
      prog.delete();
      repeat (len) prog.push_back(4'(next_random() % 15));
      prog.push_back(4'hF);
      run_program(limit);
      end_test($sformatf("random_%02d", idx), errs);
   endtask

   initial begin
      nRst = 1'b0;
      apb_req = '0;
      test_reset_values();
      if (!timed_out) test_apb_errors();
      if (!timed_out) test_arith();
      if (!timed_out) test_memory();
      if (!timed_out) test_jump();
      for (int i = 0; i < RANDOM_TESTS && !timed_out; i++) test_random(i);
      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0 && !timed_out) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: hdl/up_core_top.sv
`timescale 1ns/10ps

module up_core_top (
   input  logic                 clk,
   input  logic                 nRst,
   input  up_apb_pkg::apb_req_t apb_req,
   output up_apb_pkg::apb_rsp_t apb_rsp
);
   import up_isa_pkg::*;

   ctrl_t      ctrl;
   opcode_e    ir;
   core_regs_t regs;
   logic [7:0] data_out;
   logic [7:0] mem_rdata;
   logic [6:0] mem_addr;
   logic [7:0] limit;
   logic [7:0] count;
   logic       z;
   logic       start;
   logic       retire;
   logic       halted;
   logic       expired;

   up_control u_control (
      .clk     (clk),
      .nRst    (nRst),
      .start   (start),
      .expired (expired),
      .ir      (ir),
      .z       (z),
      .ctrl    (ctrl),
      .retire  (retire),
      .halted  (halted)
   );

   up_datapath u_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .ctrl     (ctrl),
      .data_in  (mem_rdata),
      .data_out (data_out),
      .addr     (mem_addr),
      .ir       (ir),
      .z        (z),
      .regs     (regs)
   );

   up_step_counter u_step_counter (
      .clk     (clk),
      .nRst    (nRst),
      .start   (start),
      .retire  (retire),
      .limit   (limit),
      .count   (count),
      .expired (expired)
   );

   up_apb_regs u_apb_regs (
      .clk        (clk),
      .nRst       (nRst),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .core_addr  (mem_addr),
      .core_wdata (data_out),
      .core_we    (ctrl.mem_we),
      .core_rdata (mem_rdata),
      .halted     (halted),
      .expired    (expired),
      .count      (count),
      .regs       (regs),
      .start      (start),
      .limit      (limit)
   );

endmodule

// File: hdl/up_apb_regs.sv
`timescale 1ns/10ps

module up_apb_regs (
   input  logic                   clk,
   input  logic                   nRst,
   input  up_apb_pkg::apb_req_t   apb_req,
   output up_apb_pkg::apb_rsp_t   apb_rsp,
   input  logic [6:0]             core_addr,
   input  logic [7:0]             core_wdata,
   input  logic                   core_we,
   output logic [7:0]             core_rdata,
   input  logic                   halted,
   input  logic                   expired,
   input  logic [7:0]             count,
   input  up_isa_pkg::core_regs_t regs,
   output logic                   start,
   output logic [7:0]             limit
);
   import up_apb_pkg::*;

   logic [7:0] mem [MEM_BYTES];
   logic [7:0] mem_rdata;
   logic [6:0] mem_addr;
   logic [7:0] mem_wdata;
   logic       mem_we;
   logic       access;
   logic       wr_ok;
   logic       is_mem;
   logic       is_reg;
   logic       is_mapped;
   logic       err;
   logic [7:0] rdata;

   assign access = apb_req.psel && apb_req.penable;
   assign is_mem = apb_req.paddr < MEM_BASE + MEM_BYTES;
   assign is_reg = apb_req.paddr >= REG_BASE && apb_req.paddr < REG_BASE + REG_COUNT;
   assign is_mapped = is_mem || is_reg ||
                      apb_req.paddr inside {CTRL_ADDR, STATUS_ADDR, LIMIT_ADDR, COUNT_ADDR};

   assign err = !is_mapped ||
                ((is_mem || is_reg) && !halted) ||  // Core owns memory and registers
                (apb_req.pwrite && apb_req.paddr inside {STATUS_ADDR, COUNT_ADDR});
   assign wr_ok = access && apb_req.pwrite && !err;

   // Host gets the single memory port only while the core is halted
   assign mem_addr = halted ? apb_req.paddr[6:0] : core_addr;
   assign mem_wdata = halted ? apb_req.pwdata : core_wdata;
   assign mem_we = halted ? (wr_ok && is_mem) : core_we;

   always_ff @(posedge clk) begin
      if (mem_we) mem[mem_addr] <= mem_wdata;
      mem_rdata <= mem[mem_addr];
   end

   assign core_rdata = mem_rdata;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         start <= 1'b0;
         limit <= 8'h00;
      end else begin
         start <= wr_ok && apb_req.paddr == CTRL_ADDR && apb_req.pwdata[0] && halted;
         if (wr_ok && apb_req.paddr == LIMIT_ADDR) begin
            limit <= apb_req.pwdata;
         end
      end
   end

   always_comb begin
      rdata = 8'h00;
      if (is_mem) begin
         rdata = mem_rdata;  // Read was issued in the setup phase
      end else begin
         case (apb_req.paddr)
            STATUS_ADDR:     rdata = {6'b0, expired, halted};
            LIMIT_ADDR:      rdata = limit;
            COUNT_ADDR:      rdata = count;
            REG_BASE:        rdata = regs.r0;
            REG_BASE + 8'd1: rdata = regs.r1;
            REG_BASE + 8'd2: rdata = regs.r2;
            REG_BASE + 8'd3: rdata = regs.r3;
            REG_BASE + 8'd4: rdata = regs.pc;
            REG_BASE + 8'd5: rdata = regs.sp;
            default:         rdata = 8'h00;
         endcase
      end
   end

   assign apb_rsp = '{prdata: (access && !err) ? rdata : 8'h00,
                      pready: 1'b1,
                      pslverr: access && err};

   assert property (@(posedge clk) disable iff (!nRst) core_we |-> !halted)
      else $error("core memory write while halted");

endmodule

// File: hdl/up_step_counter.sv
`timescale 1ns/10ps

module up_step_counter (
   input  logic       clk,
   input  logic       nRst,
   input  logic       start,
   input  logic       retire,
   input  logic [7:0] limit,
   output logic [7:0] count,
   output logic       expired
);

   logic [7:0] count_inc;

   assign count_inc = count + 8'd1;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         count <= 8'h00;
         expired <= 1'b0;
      end else if (start) begin
         count <= 8'h00;
         expired <= 1'b0;
      end else if (retire) begin
         if (count != 8'hFF) begin
            count <= count_inc;  // Saturates
         end
         if (limit != 8'h00 && count_inc == limit) begin
            expired <= 1'b1;
         end
      end
   end

endmodule

// File: hdl/up_datapath.sv
`timescale 1ns/10ps

module up_datapath (
   input  logic                   clk,
   input  logic                   nRst,
   input  up_isa_pkg::ctrl_t      ctrl,
   input  logic [7:0]             data_in,
   output logic [7:0]             data_out,
   output logic [6:0]             addr,
   output up_isa_pkg::opcode_e    ir,
   output logic                   z,
   output up_isa_pkg::core_regs_t regs
);
   import up_isa_pkg::*;

   logic [7:0] pc;
   logic [7:0] sp;
   logic [7:0] r0;
   logic [7:0] r1;
   logic [7:0] r2;
   logic [7:0] r3;
   logic [7:0] pc_nxt;
   logic [3:0] in_nib;

   assign in_nib = pc[0] ? data_in[3:0] : data_in[7:4];  // Low nibble on odd pc
   assign z = (r1 == r2);

   always_comb begin
      case (ctrl.op)
         UOP_ADD:     data_out = r1 + r2;
         UOP_SUB:     data_out = r1 - r2;
         UOP_MUL:     data_out = r1 * r2;
         UOP_DIV:     data_out = (r2 == 8'h00) ? 8'hFF : r1 / r2;
         UOP_NAND:    data_out = ~(r1 & r2);
         UOP_PASS_R0: data_out = r0;
         UOP_PASS_IN: data_out = {ir, in_nib};
         UOP_INC_R0:  data_out = r0 + 8'd1;
         UOP_INC_SP:  data_out = sp + 8'd1;
         UOP_DEC_SP:  data_out = sp - 8'd1;
         UOP_INC_PC:  data_out = pc + 8'd1;
         UOP_JMP_R3:  data_out = {r3[6:0], 1'b0};
         default:     data_out = data_in;
      endcase
   end

   // Byte address tracks a pc being written, so the next nibble is read early
   assign pc_nxt = ctrl.pc_we ? data_out : pc;

   always_comb begin
      case (ctrl.addr_sel)
         ADDR_R3: addr = r3[6:0];
         ADDR_SP: addr = sp[6:0];
         default: addr = pc_nxt[7:1];
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RST;
         sp <= SP_RST;
         ir <= OP_ADD;
         r0 <= R0_RST;
         r1 <= R1_RST;
         r2 <= R2_RST;
         r3 <= R3_RST;
      end else begin
         if (ctrl.ir_we) ir <= opcode_e'(in_nib);
         if (ctrl.pc_we) pc <= data_out;
         if (ctrl.sp_we) sp <= data_out;
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               SEL_I0:  r0 <= data_in;
               SEL_I1:  r1 <= data_in;
               SEL_I2:  r2 <= data_in;
               SEL_I3:  r3 <= data_in;
               SEL_00:  r0 <= data_out;
               SEL_01:  r1 <= data_out;
               SEL_02:  r2 <= data_out;
               default: r3 <= data_out;
            endcase
         end
      end
   end

   assign regs = '{r0: r0, r1: r1, r2: r2, r3: r3, pc: pc, sp: sp};

   assert property (@(posedge clk) disable iff (!nRst) !(ctrl.pc_we && ctrl.sp_we))
      else $error("pc and sp written in the same cycle");

endmodule

// File: hdl/up_control.sv
`timescale 1ns/10ps

module up_control (
   input  logic                clk,
   input  logic                nRst,
   input  logic                start,
   input  logic                expired,
   input  up_isa_pkg::opcode_e ir,
   input  logic                z,
   output up_isa_pkg::ctrl_t   ctrl,
   output logic                retire,
   output logic                halted
);
   import up_isa_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_ADDR,
      FETCH_DATA,
      EXEC,
      MEM_WAIT,
      IMM_HI,
      IMM_LO
   } state_e;

   state_e state;
   state_e state_nxt;

   function automatic ctrl_t reg_write(uop_e op, rb_sel_e sel);
      ctrl_t c;
      c = '0;
      c.op = op;
      c.rb_we = 1'b1;
      c.rb_sel = sel;
      return c;
   endfunction

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign halted = (state == IDLE);

   always_comb begin
      ctrl = '0;
      retire = 1'b0;
      state_nxt = state;
      case (state)
         IDLE: begin
            if (start) state_nxt = FETCH_ADDR;
         end
         FETCH_ADDR: begin
            state_nxt = expired ? IDLE : FETCH_DATA;  // Step limit reached
         end
         FETCH_DATA: begin
            ctrl.op = UOP_INC_PC;
            ctrl.ir_we = 1'b1;
            ctrl.pc_we = 1'b1;
            state_nxt = EXEC;
         end
         EXEC: begin
            retire = 1'b1;
            state_nxt = FETCH_ADDR;
            case (ir)
               OP_ADD:  ctrl = reg_write(UOP_ADD, SEL_00);
               OP_SUB:  ctrl = reg_write(UOP_SUB, SEL_00);
               OP_MUL:  ctrl = reg_write(UOP_MUL, SEL_00);
               OP_DIV:  ctrl = reg_write(UOP_DIV, SEL_00);
               OP_MV1:  ctrl = reg_write(UOP_PASS_R0, SEL_01);
               OP_MV2:  ctrl = reg_write(UOP_PASS_R0, SEL_02);
               OP_MV3:  ctrl = reg_write(UOP_PASS_R0, SEL_03);
               OP_INC:  ctrl = reg_write(UOP_INC_R0, SEL_00);
               OP_NAND: ctrl = reg_write(UOP_NAND, SEL_00);
               OP_STM: begin
                  ctrl.op = UOP_PASS_R0;
                  ctrl.addr_sel = ADDR_R3;
                  ctrl.mem_we = 1'b1;
               end
               OP_LDM, OP_POP: begin
                  ctrl.addr_sel = (ir == OP_POP) ? ADDR_SP : ADDR_R3;
                  retire = 1'b0;
                  state_nxt = MEM_WAIT;
               end
               OP_PUSH: begin
                  ctrl.op = UOP_DEC_SP;
                  ctrl.sp_we = 1'b1;
                  retire = 1'b0;
                  state_nxt = MEM_WAIT;
               end
               OP_JZ: begin
                  ctrl.op = UOP_JMP_R3;
                  ctrl.pc_we = z;
               end
               OP_LDI: begin
                  // High nibble was prefetched during FETCH_DATA
                  ctrl.op = UOP_INC_PC;
                  ctrl.ir_we = 1'b1;
                  ctrl.pc_we = 1'b1;
                  retire = 1'b0;
                  state_nxt = IMM_HI;
               end
               default: begin  // HLT
                  retire = 1'b0;
                  state_nxt = IDLE;
               end
            endcase
         end
         MEM_WAIT: begin
            retire = 1'b1;
            state_nxt = FETCH_ADDR;
            case (ir)
               OP_PUSH: begin
                  ctrl.op = UOP_PASS_R0;
                  ctrl.addr_sel = ADDR_SP;
                  ctrl.mem_we = 1'b1;
               end
               OP_POP: begin
                  ctrl = reg_write(UOP_INC_SP, SEL_I0);
                  ctrl.sp_we = 1'b1;
               end
               default: ctrl = reg_write(UOP_PASS_R0, SEL_I0);
            endcase
         end
         IMM_HI: begin
            ctrl = reg_write(UOP_PASS_IN, SEL_00);
            state_nxt = IMM_LO;
         end
         IMM_LO: begin
            ctrl.op = UOP_INC_PC;
            ctrl.pc_we = 1'b1;
            retire = 1'b1;
            state_nxt = FETCH_ADDR;
         end
         default: state_nxt = IDLE;
      endcase
   end

   assert property (@(posedge clk) disable iff (!nRst)
      halted |-> !(ctrl.ir_we || ctrl.pc_we || ctrl.sp_we || ctrl.rb_we || ctrl.mem_we))
      else $error("write enable raised while idle");

endmodule

// File: hdl/up_apb_pkg.sv
package up_apb_pkg;

   localparam int         MEM_BYTES   = 128;
   localparam logic [7:0] MEM_BASE    = 8'h00;
   localparam logic [7:0] CTRL_ADDR   = 8'h80;  // Start in bit 0
   localparam logic [7:0] STATUS_ADDR = 8'h81;  // Halted in bit 0 and expired in bit 1
   localparam logic [7:0] LIMIT_ADDR  = 8'h82;
   localparam logic [7:0] COUNT_ADDR  = 8'h83;
   localparam logic [7:0] REG_BASE    = 8'h84;  // r0 r1 r2 r3 pc sp
   localparam int         REG_COUNT   = 6;

   typedef struct packed {
      logic       psel;
      logic       penable;
      logic       pwrite;
      logic [7:0] paddr;
      logic [7:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [7:0] prdata;
      logic       pready;
      logic       pslverr;
   } apb_rsp_t;

endpackage

// File: hdl/up_isa_pkg.sv
package up_isa_pkg;

   localparam logic [7:0] PC_RST = 8'h00;
   localparam logic [7:0] SP_RST = 8'hFF;
   localparam logic [7:0] R0_RST = 8'h00;
   localparam logic [7:0] R1_RST = 8'h0A;
   localparam logic [7:0] R2_RST = 8'h01;
   localparam logic [7:0] R3_RST = 8'h81;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0, OP_SUB  = 4'h1, OP_MUL  = 4'h2, OP_DIV = 4'h3,
      OP_MV1  = 4'h4, OP_MV2  = 4'h5, OP_MV3  = 4'h6, OP_INC = 4'h7,
      OP_NAND = 4'h8, OP_LDM  = 4'h9, OP_STM  = 4'hA, OP_PUSH = 4'hB,
      OP_POP  = 4'hC, OP_JZ   = 4'hD, OP_LDI  = 4'hE, OP_HLT = 4'hF
   } opcode_e;

   // Result mux selections
   typedef enum logic [4:0] {
      UOP_ADD, UOP_SUB, UOP_MUL, UOP_DIV, UOP_NAND,
      UOP_PASS_R0,
      UOP_PASS_IN,       // ir nibble above the input nibble
      UOP_INC_R0, UOP_INC_SP, UOP_DEC_SP, UOP_INC_PC,
      UOP_JMP_R3
   } uop_e;

   typedef enum logic [2:0] {
      SEL_I0 = 3'b000, SEL_I1 = 3'b001, SEL_I2 = 3'b010, SEL_I3 = 3'b011,
      SEL_00 = 3'b100, SEL_01 = 3'b101, SEL_02 = 3'b110, SEL_03 = 3'b111
   } rb_sel_e;

   typedef enum logic [1:0] {
      ADDR_PC = 2'd0,
      ADDR_R3 = 2'd1,
      ADDR_SP = 2'd2
   } addr_sel_e;

   typedef struct packed {
      uop_e      op;
      logic      ir_we;
      logic      pc_we;
      logic      sp_we;
      logic      rb_we;
      rb_sel_e   rb_sel;
      addr_sel_e addr_sel;
      logic      mem_we;
   } ctrl_t;

   typedef struct packed {
      logic [7:0] r0;
      logic [7:0] r1;
      logic [7:0] r2;
      logic [7:0] r3;
      logic [7:0] pc;
      logic [7:0] sp;
   } core_regs_t;

endpackage
